// ==== logic/fpu_ss_pkg.sv ====
package fpu_ss_pkg;

  // register file size, one bit per register in the scoreboard
  localparam int unsigned NUM_REGS = 32;

  // instruction buffer entries
  localparam int unsigned BUF_DEPTH = 4;

  // cycles from issue to writeback strobe
  localparam int unsigned EXEC_LAT = 3;

  // operand and result value
  typedef logic [31:0] data_t;

  // register index
  typedef logic [4:0] reg_addr_t;

  // immediate of load-immediate, zero-extended in the pipeline
  typedef logic [15:0] imm_t;

  // buffer fill level, must reach BUF_DEPTH
  typedef logic [2:0] buf_cnt_t;

  // instruction opcodes
  // codes 5..7 are unused and decode as no-operand writers
  typedef enum logic [2:0] {
    OP_LI   = 3'd0,
    OP_MOV  = 3'd1,
    OP_ADD  = 3'd2,
    OP_SUB  = 3'd3,
    OP_MADD = 3'd4
  } opcode_e;

  // source of an operand slot
  // REG_A/B/C map to rs1/rs2/rs3
  typedef enum logic [1:0] {
    NONE  = 2'd0,
    REG_A = 2'd1,
    REG_B = 2'd2,
    REG_C = 2'd3
  } op_select_e;

endpackage : fpu_ss_pkg

// ==== logic/fpu_ss_instr_buffer.sv ====
`timescale 1ns/10ps

module fpu_ss_instr_buffer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // push side, one entry per offload strobe
  input  logic                  push_i,
  input  fpu_ss_pkg::opcode_e   push_op_i,
  input  fpu_ss_pkg::reg_addr_t push_rd_i,
  input  fpu_ss_pkg::reg_addr_t push_rs1_i,
  input  fpu_ss_pkg::reg_addr_t push_rs2_i,
  input  fpu_ss_pkg::reg_addr_t push_rs3_i,
  input  fpu_ss_pkg::imm_t      push_imm_i,
  // pop side, head entry is read without latency
  input  logic                  pop_i,
  output logic                  head_valid_o,
  output fpu_ss_pkg::opcode_e   head_op_o,
  output fpu_ss_pkg::reg_addr_t head_rd_o,
  output fpu_ss_pkg::reg_addr_t head_rs1_o,
  output fpu_ss_pkg::reg_addr_t head_rs2_o,
  output fpu_ss_pkg::reg_addr_t head_rs3_o,
  output fpu_ss_pkg::imm_t      head_imm_o,
  output logic                  full_o
);
  import fpu_ss_pkg::*;

  // entry storage
  opcode_e   op_q  [BUF_DEPTH];
  reg_addr_t rd_q  [BUF_DEPTH];
  reg_addr_t rs1_q [BUF_DEPTH];
  reg_addr_t rs2_q [BUF_DEPTH];
  reg_addr_t rs3_q [BUF_DEPTH];
  imm_t      imm_q [BUF_DEPTH];

  // pointers and fill level
  logic [$clog2(BUF_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(BUF_DEPTH)-1:0] rd_ptr_q;
  buf_cnt_t                     cnt_q;
  buf_cnt_t                     cnt_d;

  // fill level, push and pop together cancel out
  always_comb begin
    case ({push_i, pop_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      cnt_q <= cnt_d;
      // pointers wrap at the last entry
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == BUF_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == BUF_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      op_q[wr_ptr_q]  <= push_op_i;
      rd_q[wr_ptr_q]  <= push_rd_i;
      rs1_q[wr_ptr_q] <= push_rs1_i;
      rs2_q[wr_ptr_q] <= push_rs2_i;
      rs3_q[wr_ptr_q] <= push_rs3_i;
      imm_q[wr_ptr_q] <= push_imm_i;
    end
  end

  // head entry straight from storage
  assign head_valid_o = (cnt_q != '0);
  assign head_op_o    = op_q[rd_ptr_q];
  assign head_rd_o    = rd_q[rd_ptr_q];
  assign head_rs1_o   = rs1_q[rd_ptr_q];
  assign head_rs2_o   = rs2_q[rd_ptr_q];
  assign head_rs3_o   = rs3_q[rd_ptr_q];
  assign head_imm_o   = imm_q[rd_ptr_q];
  assign full_o       = (cnt_q == buf_cnt_t'(BUF_DEPTH));

  // host has no back-pressure and must watch the full flag
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o) else $error("offload while buffer full");

  // issue controller only pops a valid head
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> head_valid_o) else $error("pop from empty buffer");

endmodule : fpu_ss_instr_buffer

// ==== logic/fpu_ss_operand_decoder.sv ====
`timescale 1ns/10ps

module fpu_ss_operand_decoder (
  input  fpu_ss_pkg::opcode_e          op_i,
  // operand slot sources, slot 0 first
  output fpu_ss_pkg::op_select_e [2:0] op_select_o,
  // instruction writes its rd
  output logic                         rd_writes_o
);
  import fpu_ss_pkg::*;

  // opcode table
  // every current opcode writes rd, a store-like one would clear the flag
  always_comb begin
    op_select_o[0] = NONE;
    op_select_o[1] = NONE;
    op_select_o[2] = NONE;
    rd_writes_o    = 1'b1;
    case (op_i)
      OP_LI: begin
        // immediate only, no register read
        rd_writes_o = 1'b1;
      end
      OP_MOV: begin
        op_select_o[0] = REG_A;
        rd_writes_o    = 1'b1;
      end
      OP_ADD, OP_SUB: begin
        op_select_o[0] = REG_A;
        op_select_o[1] = REG_B;
        rd_writes_o    = 1'b1;
      end
      OP_MADD: begin
        // rs1 * rs2 + rs3
        op_select_o[0] = REG_A;
        op_select_o[1] = REG_B;
        op_select_o[2] = REG_C;
        rd_writes_o    = 1'b1;
      end
      default: begin
        rd_writes_o = 1'b1;
      end
    endcase
  end

endmodule : fpu_ss_operand_decoder

// ==== logic/fpu_ss_issue_controller.sv ====
`timescale 1ns/10ps

module fpu_ss_issue_controller (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // head of the instruction buffer
  input  logic                         head_valid_i,
  input  logic                         rd_writes_i,
  input  fpu_ss_pkg::op_select_e [2:0] op_select_i,
  input  fpu_ss_pkg::reg_addr_t        rd_i,
  input  fpu_ss_pkg::reg_addr_t        rs1_i,
  input  fpu_ss_pkg::reg_addr_t        rs2_i,
  input  fpu_ss_pkg::reg_addr_t        rs3_i,
  // writeback of the execution pipeline
  input  logic                         wb_valid_i,
  input  fpu_ss_pkg::reg_addr_t        wb_rd_i,
  // issue strobe, also pops the buffer
  output logic                         issue_valid_o,
  // per source forwarding select
  output logic                   [2:0] fwd_o
);
  import fpu_ss_pkg::*;

  // one pending-write bit per register
  logic [NUM_REGS-1:0] rd_scoreboard_q;
  logic [NUM_REGS-1:0] rd_scoreboard_d;

  // source is used by any operand slot
  logic use_rs1;
  logic use_rs2;
  logic use_rs3;

  // dependencies
  logic dep_rs1;
  logic dep_rs2;
  logic dep_rs3;
  logic dep_rs;
  logic dep_rd;

  assign use_rs1 = (op_select_i[0] == REG_A) | (op_select_i[1] == REG_A) |
                   (op_select_i[2] == REG_A);
  assign use_rs2 = (op_select_i[0] == REG_B) | (op_select_i[1] == REG_B) |
                   (op_select_i[2] == REG_B);
  assign use_rs3 = (op_select_i[0] == REG_C) | (op_select_i[1] == REG_C) |
                   (op_select_i[2] == REG_C);

  // read-after-write against any write still in flight
  assign dep_rs1 = head_valid_i & use_rs1 & rd_scoreboard_q[rs1_i];
  assign dep_rs2 = head_valid_i & use_rs2 & rd_scoreboard_q[rs2_i];
  assign dep_rs3 = head_valid_i & use_rs3 & rd_scoreboard_q[rs3_i];

  // a pending source that retires this cycle is taken from the writeback bus
  assign fwd_o[0] = dep_rs1 & wb_valid_i & (rs1_i == wb_rd_i);
  assign fwd_o[1] = dep_rs2 & wb_valid_i & (rs2_i == wb_rd_i);
  assign fwd_o[2] = dep_rs3 & wb_valid_i & (rs3_i == wb_rd_i);

  assign dep_rs = (dep_rs1 & ~fwd_o[0]) | (dep_rs2 & ~fwd_o[1]) | (dep_rs3 & ~fwd_o[2]);

  // write-after-write, unless the older write leaves this cycle
  // results retire in order so the newer write still lands last
  assign dep_rd = rd_writes_i & rd_scoreboard_q[rd_i] & ~(wb_valid_i & (wb_rd_i == rd_i));

  assign issue_valid_o = head_valid_i & ~dep_rs & ~dep_rd;

  // scoreboard update
  always_comb begin
    rd_scoreboard_d = rd_scoreboard_q;
    // clear before set, so a same-register issue keeps the bit
    if (wb_valid_i) begin
      rd_scoreboard_d[wb_rd_i] = 1'b0;
    end
    if (issue_valid_o & rd_writes_i) begin
      rd_scoreboard_d[rd_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_scoreboard_q <= '0;
    end else begin
      rd_scoreboard_q <= rd_scoreboard_d;
    end
  end

  // every result in the pipeline was registered at issue
  a_wb_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_valid_i |-> rd_scoreboard_q[wb_rd_i]) else $error("writeback to idle register");

endmodule : fpu_ss_issue_controller

// ==== logic/fpu_ss_exec_pipe.sv ====
`timescale 1ns/10ps

module fpu_ss_exec_pipe (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // issue side
  input  logic                  in_valid_i,
  input  fpu_ss_pkg::opcode_e   in_op_i,
  input  fpu_ss_pkg::reg_addr_t in_rd_i,
  input  fpu_ss_pkg::data_t     in_a_i,
  input  fpu_ss_pkg::data_t     in_b_i,
  input  fpu_ss_pkg::data_t     in_c_i,
  input  fpu_ss_pkg::imm_t      in_imm_i,
  // writeback side
  output logic                  out_valid_o,
  output fpu_ss_pkg::reg_addr_t out_rd_o,
  output fpu_ss_pkg::data_t     out_data_o
);
  import fpu_ss_pkg::*;

  // valid bit per stage
  logic s1_valid_q;
  logic s2_valid_q;
  logic s3_valid_q;

  // stage 1, captured operands
  opcode_e   s1_op_q;
  reg_addr_t s1_rd_q;
  data_t     s1_a_q;
  data_t     s1_b_q;
  data_t     s1_c_q;
  imm_t      s1_imm_q;

  // stage 2, x is product or passed a, y the addend
  opcode_e   s2_op_q;
  reg_addr_t s2_rd_q;
  data_t     s2_x_q;
  data_t     s2_y_q;
  imm_t      s2_imm_q;

  // stage 3, final result
  reg_addr_t s3_rd_q;
  data_t     s3_data_q;

  // no stall anywhere, valids just shift
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
      s3_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= in_valid_i;
      s2_valid_q <= s1_valid_q;
      s3_valid_q <= s2_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_op_q  <= in_op_i;
    s1_rd_q  <= in_rd_i;
    s1_a_q   <= in_a_i;
    s1_b_q   <= in_b_i;
    s1_c_q   <= in_c_i;
    s1_imm_q <= in_imm_i;

    s2_op_q  <= s1_op_q;
    s2_rd_q  <= s1_rd_q;
    s2_imm_q <= s1_imm_q;
    // multiply part of madd, low 32 bits kept
    if (s1_op_q == OP_MADD) begin
      s2_x_q <= s1_a_q * s1_b_q;
      s2_y_q <= s1_c_q;
    end else begin
      s2_x_q <= s1_a_q;
      s2_y_q <= s1_b_q;
    end

    s3_rd_q <= s2_rd_q;
    case (s2_op_q)
      OP_LI:           s3_data_q <= {16'b0, s2_imm_q};
      OP_MOV:          s3_data_q <= s2_x_q;
      OP_ADD, OP_MADD: s3_data_q <= s2_x_q + s2_y_q;
      OP_SUB:          s3_data_q <= s2_x_q - s2_y_q;
      default:         s3_data_q <= '0;
    endcase
  end

  assign out_valid_o = s3_valid_q;
  assign out_rd_o    = s3_rd_q;
  assign out_data_o  = s3_data_q;

endmodule : fpu_ss_exec_pipe

// ==== logic/fpu_ss_regfile.sv ====
`timescale 1ns/10ps

module fpu_ss_regfile (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // read ports for rs1, rs2, rs3
  input  fpu_ss_pkg::reg_addr_t raddr_a_i,
  input  fpu_ss_pkg::reg_addr_t raddr_b_i,
  input  fpu_ss_pkg::reg_addr_t raddr_c_i,
  // bypass select per read port
  input  logic            [2:0] fwd_i,
  // single write port from the pipeline
  input  logic                  we_i,
  input  fpu_ss_pkg::reg_addr_t waddr_i,
  input  fpu_ss_pkg::data_t     wdata_i,
  output fpu_ss_pkg::data_t     rdata_a_o,
  output fpu_ss_pkg::data_t     rdata_b_o,
  output fpu_ss_pkg::data_t     rdata_c_o
);
  import fpu_ss_pkg::*;

  // register storage
  data_t regs_q [NUM_REGS];

  // write lands at the edge that ends the writeback cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '{default: '0};
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // the stored value is still stale during writeback, so take wdata
  assign rdata_a_o = fwd_i[0] ? wdata_i : regs_q[raddr_a_i];
  assign rdata_b_o = fwd_i[1] ? wdata_i : regs_q[raddr_b_i];
  assign rdata_c_o = fwd_i[2] ? wdata_i : regs_q[raddr_c_i];

endmodule : fpu_ss_regfile

// ==== logic/fpu_ss_top.sv ====
`timescale 1ns/10ps

module fpu_ss_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // offload strobe from the host
  input  logic                  offload_valid_i,
  input  fpu_ss_pkg::opcode_e   offload_op_i,
  input  fpu_ss_pkg::reg_addr_t offload_rd_i,
  input  fpu_ss_pkg::reg_addr_t offload_rs1_i,
  input  fpu_ss_pkg::reg_addr_t offload_rs2_i,
  input  fpu_ss_pkg::reg_addr_t offload_rs3_i,
  input  fpu_ss_pkg::imm_t      offload_imm_i,
  // host holds offloads while high
  output logic                  buf_full_o,
  // result strobe
  output logic                  wb_valid_o,
  output fpu_ss_pkg::reg_addr_t wb_rd_o,
  output fpu_ss_pkg::data_t     wb_data_o
);
  import fpu_ss_pkg::*;

  // buffer head
  logic      head_valid;
  opcode_e   head_op;
  reg_addr_t head_rd;
  reg_addr_t head_rs1;
  reg_addr_t head_rs2;
  reg_addr_t head_rs3;
  imm_t      head_imm;

  // decode and issue
  op_select_e [2:0] op_select;
  logic             rd_writes;
  logic             issue_valid;
  logic       [2:0] fwd;

  // operands and writeback
  data_t     rdata_a;
  data_t     rdata_b;
  data_t     rdata_c;
  logic      wb_valid;
  reg_addr_t wb_rd;
  data_t     wb_data;

  fpu_ss_instr_buffer u_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (offload_valid_i),
    .push_op_i    (offload_op_i),
    .push_rd_i    (offload_rd_i),
    .push_rs1_i   (offload_rs1_i),
    .push_rs2_i   (offload_rs2_i),
    .push_rs3_i   (offload_rs3_i),
    .push_imm_i   (offload_imm_i),
    .pop_i        (issue_valid),
    .head_valid_o (head_valid),
    .head_op_o    (head_op),
    .head_rd_o    (head_rd),
    .head_rs1_o   (head_rs1),
    .head_rs2_o   (head_rs2),
    .head_rs3_o   (head_rs3),
    .head_imm_o   (head_imm),
    .full_o       (buf_full_o)
  );

  fpu_ss_operand_decoder u_decoder (
    .op_i        (head_op),
    .op_select_o (op_select),
    .rd_writes_o (rd_writes)
  );

  fpu_ss_issue_controller u_controller (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .head_valid_i  (head_valid),
    .rd_writes_i   (rd_writes),
    .op_select_i   (op_select),
    .rd_i          (head_rd),
    .rs1_i         (head_rs1),
    .rs2_i         (head_rs2),
    .rs3_i         (head_rs3),
    .wb_valid_i    (wb_valid),
    .wb_rd_i       (wb_rd),
    .issue_valid_o (issue_valid),
    .fwd_o         (fwd)
  );

  // operands are read in the issue cycle
  fpu_ss_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (head_rs1),
    .raddr_b_i (head_rs2),
    .raddr_c_i (head_rs3),
    .fwd_i     (fwd),
    .we_i      (wb_valid),
    .waddr_i   (wb_rd),
    .wdata_i   (wb_data),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .rdata_c_o (rdata_c)
  );

  fpu_ss_exec_pipe u_exec (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (issue_valid),
    .in_op_i     (head_op),
    .in_rd_i     (head_rd),
    .in_a_i      (rdata_a),
    .in_b_i      (rdata_b),
    .in_c_i      (rdata_c),
    .in_imm_i    (head_imm),
    .out_valid_o (wb_valid),
    .out_rd_o    (wb_rd),
    .out_data_o  (wb_data)
  );

  // writeback also goes to the host
  assign wb_valid_o = wb_valid;
  assign wb_rd_o    = wb_rd;
  assign wb_data_o  = wb_data;

endmodule : fpu_ss_top

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // 40 ns period
  localparam time HALF_PERIOD = 20ns;

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    // reset held for 3 cycles, released on a rising edge
    repeat (3) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule : tb_clock_gen

// ==== sim/tb_fpu_ss.sv ====
`timescale 1ns/10ps

module tb_fpu_ss;
  import fpu_ss_pkg::*;

  localparam time CLK_PERIOD = 40ns;

  // instructions per test section, they also size the watchdog
  localparam int NUM_OPCODE  = 7;
  localparam int NUM_LATENCY = 1;
  localparam int CHAIN_LEN   = 20;
  localparam int NUM_WAW     = 4;
  localparam int BURST_LEN   = 20;
  localparam int NUM_RANDOM  = 500;
  localparam int NUM_INSTR   = NUM_OPCODE + NUM_LATENCY + CHAIN_LEN + 1 + NUM_WAW +
                               BURST_LEN + 1 + NUM_RANDOM;
  localparam time TIMEOUT    = CLK_PERIOD * (NUM_INSTR * (EXEC_LAT + 2) + 100);

  logic      clk;
  logic      rst_n;

  // host side
  logic      offload_valid;
  opcode_e   offload_op;
  reg_addr_t offload_rd;
  reg_addr_t offload_rs1;
  reg_addr_t offload_rs2;
  reg_addr_t offload_rs3;
  imm_t      offload_imm;
  logic      buf_full;
  logic      wb_valid;
  reg_addr_t wb_rd;
  data_t     wb_data;

  // sequential reference model and expected writebacks in offload order
  data_t     model_regs [NUM_REGS];
  reg_addr_t exp_rd_q [$];
  data_t     exp_data_q [$];

  int        seed = 60;
  logic      saw_full;

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  fpu_ss_top dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .offload_valid_i (offload_valid),
    .offload_op_i    (offload_op),
    .offload_rd_i    (offload_rd),
    .offload_rs1_i   (offload_rs1),
    .offload_rs2_i   (offload_rs2),
    .offload_rs3_i   (offload_rs3),
    .offload_imm_i   (offload_imm),
    .buf_full_o      (buf_full),
    .wb_valid_o      (wb_valid),
    .wb_rd_o         (wb_rd),
    .wb_data_o       (wb_data)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_addr(input reg_addr_t act, input reg_addr_t exp, input string what);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %0t: %s is r%0d, expected r%0d", $time, what, act, exp));
    end
  endtask

  task automatic compare_data(input data_t act, input data_t exp, input string what);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %0t: %s is 0x%08h, expected 0x%08h", $time, what, act, exp));
    end
  endtask

  task automatic compare_latency(input int act, input int exp, input string what);
    if (act != exp) begin
      abort_run($sformatf("FAIL %0t: %s is %0d, expected %0d", $time, what, act, exp));
    end
  endtask

  // result of one instruction, 32-bit wraparound everywhere
  function automatic data_t predict_result(input opcode_e op, input data_t a, input data_t b,
                                           input data_t c, input imm_t imm);
    case (op)
      OP_LI:   return {16'h0000, imm};
      OP_MOV:  return a;
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_MADD: return a * b + c;
      default: return '0;
    endcase
  endfunction

  // small register range keeps hazards frequent
  function automatic reg_addr_t pick_reg();
    return reg_addr_t'($unsigned($random(seed)) % 8);
  endfunction

  function automatic imm_t pick_imm();
    return imm_t'($random(seed));
  endfunction

  function automatic opcode_e pick_op(input int unsigned first, input int unsigned count);
    logic [2:0] code;
    code = 3'(first + $unsigned($random(seed)) % count);
    return opcode_e'(code);
  endfunction

  // one offload strobe, never while full
  // full only reflects a push one edge later, so a strobe is always followed by an idle cycle
  task automatic send_instr(input opcode_e op, input reg_addr_t rd, input reg_addr_t rs1,
                            input reg_addr_t rs2, input reg_addr_t rs3, input imm_t imm);
    data_t result;
    @(posedge clk);
    offload_valid <= 1'b0;
    while (buf_full || offload_valid) begin
      @(posedge clk);
      offload_valid <= 1'b0;
    end
    offload_valid <= 1'b1;
    offload_op    <= op;
    offload_rd    <= rd;
    offload_rs1   <= rs1;
    offload_rs2   <= rs2;
    offload_rs3   <= rs3;
    offload_imm   <= imm;
    result = predict_result(op, model_regs[rs1], model_regs[rs2], model_regs[rs3], imm);
    model_regs[rd] = result;
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(result);
  endtask

  // all offloaded instructions written back, pipeline and buffer empty
  task automatic wait_idle();
    @(posedge clk);
    offload_valid <= 1'b0;
    while (exp_rd_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // every opcode, with products and sums that wrap
  task automatic run_opcode_test();
    send_instr(OP_LI, 5'd1, 5'd0, 5'd0, 5'd0, 16'hffff);
    send_instr(OP_LI, 5'd2, 5'd0, 5'd0, 5'd0, 16'h0001);
    send_instr(OP_MADD, 5'd3, 5'd1, 5'd1, 5'd2, 16'h0000);
    send_instr(OP_ADD, 5'd4, 5'd3, 5'd3, 5'd0, 16'h0000);
    send_instr(OP_SUB, 5'd5, 5'd2, 5'd1, 5'd0, 16'h0000);
    send_instr(OP_MOV, 5'd6, 5'd5, 5'd0, 5'd0, 16'h0000);
    send_instr(OP_ADD, 5'd4, 5'd6, 5'd3, 5'd0, 16'h0000);
  endtask

  // isolated instruction, one cycle to the buffer head plus the pipeline
  task automatic run_latency_test();
    int lat;
    wait_idle();
    send_instr(OP_ADD, 5'd3, 5'd1, 5'd2, 5'd0, 16'h0000);
    // edge that accepts the offload
    @(posedge clk);
    offload_valid <= 1'b0;
    lat = 0;
    while (!wb_valid && lat < 4 * EXEC_LAT + 8) begin
      @(posedge clk);
      lat++;
    end
    compare_latency(lat, EXEC_LAT + 1, "offload to writeback cycles");
  endtask

  // each instruction reads the rd of the one before
  task automatic run_chain_test();
    reg_addr_t prev;
    reg_addr_t rd;
    prev = 5'd2;
    send_instr(OP_LI, prev, 5'd0, 5'd0, 5'd0, 16'hbeef);
    for (int i = 0; i < CHAIN_LEN; i++) begin
      rd = pick_reg();
      send_instr(pick_op(1, 4), rd, prev, pick_reg(), prev, pick_imm());
      prev = rd;
    end
  endtask

  // two writes to r7, then readers that must see the later one
  task automatic run_waw_test();
    send_instr(OP_LI, 5'd7, 5'd0, 5'd0, 5'd0, 16'h1111);
    send_instr(OP_LI, 5'd7, 5'd0, 5'd0, 5'd0, 16'h2222);
    send_instr(OP_MOV, 5'd0, 5'd7, 5'd0, 5'd0, 16'h0000);
    send_instr(OP_ADD, 5'd7, 5'd7, 5'd0, 5'd0, 16'h0000);
  endtask

  // a madd chain issues every EXEC_LAT cycles, slower than offloads, so the buffer fills
  task automatic run_burst_test();
    wait_idle();
    saw_full = 1'b0;
    send_instr(OP_LI, 5'd1, 5'd0, 5'd0, 5'd0, 16'h0003);
    for (int i = 0; i < BURST_LEN; i++) begin
      send_instr(OP_MADD, 5'd1, 5'd1, 5'd1, 5'd1, 16'h0000);
    end
    wait_idle();
    if (!saw_full) begin
      abort_run("buffer never reported full during the dependent burst");
    end
  endtask

  task automatic run_random_test();
    for (int i = 0; i < NUM_RANDOM; i++) begin
      send_instr(pick_op(0, 5), pick_reg(), pick_reg(), pick_reg(), pick_reg(), pick_imm());
    end
  endtask

  // writeback monitor, outputs are flops and stable at the edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (buf_full) begin
        saw_full = 1'b1;
      end
      if (wb_valid) begin
        if (exp_rd_q.size() == 0) begin
          abort_run($sformatf("FAIL %0t: writeback to r%0d with nothing outstanding",
                              $time, wb_rd));
        end else begin
          compare_addr(wb_rd, exp_rd_q[0], "writeback rd");
          compare_data(wb_data, exp_data_q[0], "writeback data");
          void'(exp_rd_q.pop_front());
          void'(exp_data_q.pop_front());
        end
      end
    end
  end

  // watchdog
  initial begin
    #(TIMEOUT);
    $display("watchdog expired after %0t, expected writebacks never arrived", TIMEOUT);
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    offload_valid = 1'b0;
    offload_op    = OP_LI;
    offload_rd    = '0;
    offload_rs1   = '0;
    offload_rs2   = '0;
    offload_rs3   = '0;
    offload_imm   = '0;
    saw_full      = 1'b0;
    // register file resets to zero
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    wait (rst_n === 1'b1);
    run_opcode_test();
    run_latency_test();
    run_chain_test();
    run_waw_test();
    run_burst_test();
    run_random_test();
    // returns only once every expected writeback arrived
    wait_idle();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule : tb_fpu_ss

// ==== project.f ====
logic/fpu_ss_pkg.sv
logic/fpu_ss_instr_buffer.sv
logic/fpu_ss_operand_decoder.sv
logic/fpu_ss_issue_controller.sv
logic/fpu_ss_exec_pipe.sv
logic/fpu_ss_regfile.sv
logic/fpu_ss_top.sv
sim/tb_clock_gen.sv
sim/tb_fpu_ss.sv
